//--- Bender.yml
package:
  name: mips_pipeline

sources:
  - files:
      - mips_pkg.sv
      - stage_ctrl_if.sv
      - pipeline_control.sv
      - fetch_unit.sv
      - register_file.sv
      - execute_unit.sv
      - memory_writeback.sv
      - mips_pipeline.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mips_pipeline.sv

//--- execute_unit.sv
////////////////////
// execute unit
// decode/execute register, alu, execute/memory register
////////////////////
`timescale 1ns/1ps

module execute_unit import mips_pkg::*;
(
    input  logic      SYS_clk,
    input  logic      SYS_reset,
    stage_ctrl_if.dp  ctl,
    input  word_t     id_instr,
    input  word_t     rs_data,
    input  word_t     rt_data,
    output reg_addr_t rs_addr,
    output reg_addr_t rt_addr,
    output word_t     mem_alu_result,
    output word_t     mem_store_data,
    output reg_addr_t mem_dest
);

    imm_t      id_imm;
    reg_addr_t id_rd;

    word_t     ex_rs_val;
    word_t     ex_rt_val;
    word_t     ex_imm;     // sign extended
    reg_addr_t ex_rt;
    reg_addr_t ex_rd;

    word_t     alu_b;
    word_t     alu_result;
    reg_addr_t ex_dest;

    // instruction fields
    assign ctl.id_opcode = opcode_e'(id_instr[31:26]);
    assign ctl.id_funct  = id_instr[5:0];
    assign rs_addr       = id_instr[25:21];
    assign rt_addr       = id_instr[20:16];
    assign id_rd         = id_instr[15:11];
    assign id_imm        = id_instr[15:0];

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            ex_rs_val <= '0;
            ex_rt_val <= '0;
            ex_imm    <= '0;
            ex_rt     <= '0;
            ex_rd     <= '0;
        end
        else
        begin
            ex_rs_val <= rs_data;
            ex_rt_val <= rt_data;
            ex_imm    <= {{16{id_imm[15]}}, id_imm};
            ex_rt     <= rt_addr;
            ex_rd     <= id_rd;
        end
    end

    assign ex_dest = ctl.ex_reg_dst_rd ? ex_rd : ex_rt;          // r-type writes rd
    assign alu_b   = ctl.ex_alu_src_imm ? ex_imm : ex_rt_val;

    always_comb
    begin
        case (ctl.ex_alu_op)
            ALU_ADD:    alu_result = ex_rs_val + alu_b;
            ALU_SUB:    alu_result = ex_rs_val - alu_b;
            ALU_AND:    alu_result = ex_rs_val & alu_b;
            ALU_OR:     alu_result = ex_rs_val | alu_b;
            ALU_SLT:    alu_result = {31'b0, $signed(ex_rs_val) < $signed(alu_b)};
            ALU_PASS_B: alu_result = alu_b;
            default:    alu_result = alu_b;
        endcase
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            mem_alu_result <= '0;
            mem_store_data <= '0;
            mem_dest       <= '0;
        end
        else
        begin
            mem_alu_result <= alu_result;
            mem_store_data <= ex_rt_val;  // sw data is rt
            mem_dest       <= ex_dest;
        end
    end

endmodule

//--- fetch_unit.sv
////////////////////
// fetch unit
// pc, instruction memory with load port, fetch/decode register
////////////////////
`timescale 1ns/1ps

module fetch_unit import mips_pkg::*;
#(
    parameter int IMEM_ADDR_W = 6
)
(
    input  logic                   SYS_clk,
    input  logic                   SYS_reset,
    input  logic                   load_en,
    input  logic [IMEM_ADDR_W-1:0] load_addr,
    input  word_t                  load_data,
    output word_t                  id_instr
);

    word_t imem [2**IMEM_ADDR_W];
    word_t pc;
    word_t fetch_instr;

    // program load port
    always_ff @(posedge SYS_clk)
    begin
        if (load_en)
            imem[load_addr] <= load_data;
    end

    assign fetch_instr = imem[pc[IMEM_ADDR_W+1:2]];  // word index

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || load_en)
        begin
            pc       <= '0;
            id_instr <= '0;  // nop while loading
        end
        else
        begin
            pc       <= pc + 32'd4;
            id_instr <= fetch_instr;
        end
    end

    pc_word_aligned: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        pc[1:0] == 2'b00)
        else $error("pc lost word alignment");

endmodule

//--- memory_writeback.sv
////////////////////
// memory and write-back
// data memory, memory/write-back register, result select
////////////////////
`timescale 1ns/1ps

module memory_writeback import mips_pkg::*;
#(
    parameter int DMEM_ADDR_W = 6
)
(
    input  logic      SYS_clk,
    input  logic      SYS_reset,
    stage_ctrl_if.dp  ctl,
    input  word_t     mem_alu_result,
    input  word_t     mem_store_data,
    input  reg_addr_t mem_dest,
    output reg_addr_t wb_addr,
    output word_t     wb_data
);

    word_t                  dmem [2**DMEM_ADDR_W];
    logic [DMEM_ADDR_W-1:0] dmem_idx;
    word_t                  mem_load_data;

    word_t                  wb_load_data;
    word_t                  wb_alu_result;

    assign dmem_idx = mem_alu_result[DMEM_ADDR_W+1:2];  // byte address to word

    // store at the end of the memory stage
    always_ff @(posedge SYS_clk)
    begin
        if (ctl.mem_write)
            dmem[dmem_idx] <= mem_store_data;
    end

    assign mem_load_data = ctl.mem_read ? dmem[dmem_idx] : '0;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            wb_load_data  <= '0;
            wb_alu_result <= '0;
            wb_addr       <= '0;
        end
        else
        begin
            wb_load_data  <= mem_load_data;
            wb_alu_result <= mem_alu_result;
            wb_addr       <= mem_dest;
        end
    end

    assign wb_data = ctl.wb_mem_to_reg ? wb_load_data : wb_alu_result;  // lw result

endmodule

//--- mips_pipeline.sv
////////////////////
// five-stage mips pipeline top
////////////////////
`timescale 1ns/1ps

module mips_pipeline import mips_pkg::*;
#(
    parameter int IMEM_ADDR_W = 6,
    parameter int DMEM_ADDR_W = 6
)
(
    input  logic                   SYS_clk,
    input  logic                   SYS_reset,
    input  logic                   load_en,
    input  logic [IMEM_ADDR_W-1:0] load_addr,
    input  word_t                  load_data,
    input  reg_addr_t              reg_sel,
    output word_t                  reg_value
);

    word_t     id_instr;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;
    word_t     mem_alu_result;
    word_t     mem_store_data;
    reg_addr_t mem_dest;
    reg_addr_t wb_addr;
    word_t     wb_data;

    stage_ctrl_if ctl_if ();

    pipeline_control pipeline_control_i
    (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .ctl       (ctl_if.ctrl)
    );

    fetch_unit #(.IMEM_ADDR_W(IMEM_ADDR_W)) fetch_unit_i
    (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .id_instr  (id_instr)
    );

    register_file register_file_i
    (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .ctl       (ctl_if.dp),
        .rs_addr   (rs_addr),
        .rt_addr   (rt_addr),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .dbg_addr  (reg_sel),    // debug read
        .dbg_data  (reg_value)
    );

    execute_unit execute_unit_i
    (
        .SYS_clk        (SYS_clk),
        .SYS_reset      (SYS_reset),
        .ctl            (ctl_if.dp),
        .id_instr       (id_instr),
        .rs_data        (rs_data),
        .rt_data        (rt_data),
        .rs_addr        (rs_addr),
        .rt_addr        (rt_addr),
        .mem_alu_result (mem_alu_result),
        .mem_store_data (mem_store_data),
        .mem_dest       (mem_dest)
    );

    memory_writeback #(.DMEM_ADDR_W(DMEM_ADDR_W)) memory_writeback_i
    (
        .SYS_clk        (SYS_clk),
        .SYS_reset      (SYS_reset),
        .ctl            (ctl_if.dp),
        .mem_alu_result (mem_alu_result),
        .mem_store_data (mem_store_data),
        .mem_dest       (mem_dest),
        .wb_addr        (wb_addr),
        .wb_data        (wb_data)
    );

endmodule

//--- mips_pkg.sv
////////////////////
// mips core package
// widths, opcode and funct codes, alu operations
////////////////////
package mips_pkg;

    typedef logic [31:0] word_t;      // data word or instruction
    typedef logic [4:0]  reg_addr_t;  // register number
    typedef logic [15:0] imm_t;       // raw immediate field
    typedef logic [5:0]  funct_t;     // r-type funct field

    localparam int REG_COUNT = 32;

    // primary opcode, bits 31:26
    typedef enum logic [5:0]
    {
        OP_RTYPE = 6'h00,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    localparam funct_t FUNCT_ADD = 6'h20;
    localparam funct_t FUNCT_SUB = 6'h22;
    localparam funct_t FUNCT_AND = 6'h24;
    localparam funct_t FUNCT_OR  = 6'h25;
    localparam funct_t FUNCT_SLT = 6'h2a;

    // zero encoding is the nop operation
    typedef enum logic [2:0]
    {
        ALU_PASS_B = 3'd0,
        ALU_ADD    = 3'd1,
        ALU_SUB    = 3'd2,
        ALU_AND    = 3'd3,
        ALU_OR     = 3'd4,
        ALU_SLT    = 3'd5  // signed compare
    } alu_op_e;

endpackage

//--- pipeline_control.sv
////////////////////
// pipeline control
// decoder, alu control and the control pipeline registers
////////////////////
`timescale 1ns/1ps

module pipeline_control import mips_pkg::*;
(
    input logic         SYS_clk,
    input logic         SYS_reset,
    stage_ctrl_if.ctrl  ctl
);

    alu_op_e rtype_alu_op;
    logic    rtype_valid;

    alu_op_e id_alu_op;
    logic    id_alu_src_imm;
    logic    id_reg_dst_rd;
    logic    id_mem_read;
    logic    id_mem_write;
    logic    id_reg_write;
    logic    id_mem_to_reg;

    logic    ex_mem_read;
    logic    ex_mem_write;
    logic    ex_reg_write;
    logic    ex_mem_to_reg;

    logic    mem_reg_write;
    logic    mem_mem_to_reg;

    // alu control from funct
    always_comb
    begin
        rtype_valid = 1'b1;
        case (ctl.id_funct)
            FUNCT_ADD: rtype_alu_op = ALU_ADD;
            FUNCT_SUB: rtype_alu_op = ALU_SUB;
            FUNCT_AND: rtype_alu_op = ALU_AND;
            FUNCT_OR:  rtype_alu_op = ALU_OR;
            FUNCT_SLT: rtype_alu_op = ALU_SLT;
            default:
            begin
                rtype_alu_op = ALU_PASS_B;
                rtype_valid  = 1'b0;  // unknown funct retires as nop
            end
        endcase
    end

    // main decoder
    always_comb
    begin
        id_alu_op      = ALU_PASS_B;
        id_alu_src_imm = 1'b0;
        id_reg_dst_rd  = 1'b0;
        id_mem_read    = 1'b0;
        id_mem_write   = 1'b0;
        id_reg_write   = 1'b0;
        id_mem_to_reg  = 1'b0;
        case (ctl.id_opcode)
            OP_RTYPE:
            begin
                id_alu_op     = rtype_alu_op;
                id_reg_dst_rd = rtype_valid;
                id_reg_write  = rtype_valid;
            end
            OP_ADDI:
            begin
                id_alu_op      = ALU_ADD;
                id_alu_src_imm = 1'b1;
                id_reg_write   = 1'b1;
            end
            OP_LW:
            begin
                id_alu_op      = ALU_ADD;  // base + offset
                id_alu_src_imm = 1'b1;
                id_mem_read    = 1'b1;
                id_reg_write   = 1'b1;
                id_mem_to_reg  = 1'b1;
            end
            OP_SW:
            begin
                id_alu_op      = ALU_ADD;
                id_alu_src_imm = 1'b1;
                id_mem_write   = 1'b1;
            end
            default:
            begin
                id_alu_op = ALU_PASS_B;  // all-zero controls
            end
        endcase
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            ctl.ex_alu_op      <= ALU_PASS_B;
            ctl.ex_alu_src_imm <= 1'b0;
            ctl.ex_reg_dst_rd  <= 1'b0;
            ex_mem_read        <= 1'b0;
            ex_mem_write       <= 1'b0;
            ex_reg_write       <= 1'b0;
            ex_mem_to_reg      <= 1'b0;
            ctl.mem_read       <= 1'b0;
            ctl.mem_write      <= 1'b0;
            mem_reg_write      <= 1'b0;
            mem_mem_to_reg     <= 1'b0;
            ctl.wb_reg_write   <= 1'b0;
            ctl.wb_mem_to_reg  <= 1'b0;
        end
        else
        begin
            ctl.ex_alu_op      <= id_alu_op;       // execute stage
            ctl.ex_alu_src_imm <= id_alu_src_imm;
            ctl.ex_reg_dst_rd  <= id_reg_dst_rd;
            ex_mem_read        <= id_mem_read;
            ex_mem_write       <= id_mem_write;
            ex_reg_write       <= id_reg_write;
            ex_mem_to_reg      <= id_mem_to_reg;
            ctl.mem_read       <= ex_mem_read;     // memory stage
            ctl.mem_write      <= ex_mem_write;
            mem_reg_write      <= ex_reg_write;
            mem_mem_to_reg     <= ex_mem_to_reg;
            ctl.wb_reg_write   <= mem_reg_write;   // write-back stage
            ctl.wb_mem_to_reg  <= mem_mem_to_reg;
        end
    end

    mem_rw_exclusive: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        !(ctl.mem_read && ctl.mem_write))
        else $error("memory stage has read and write active together");

endmodule

//--- register_file.sv
////////////////////
// register file
// two write-through read ports, one write port, debug read
////////////////////
`timescale 1ns/1ps

module register_file import mips_pkg::*;
(
    input  logic      SYS_clk,
    input  logic      SYS_reset,
    stage_ctrl_if.dp  ctl,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    output word_t     rs_data,
    output word_t     rt_data,
    input  reg_addr_t dbg_addr,
    output word_t     dbg_data
);

    word_t regs [REG_COUNT];
    logic  wr_en;

    assign wr_en = ctl.wb_reg_write && (wb_addr != '0);  // r0 stays zero

    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0)
            return '0;
        else if (wr_en && (addr == wb_addr))
            return wb_data;  // same-cycle write passes through
        else
            return regs[addr];
    endfunction

    always_comb
    begin
        rs_data  = read_port(rs_addr);
        rt_data  = read_port(rt_addr);
        dbg_data = regs[dbg_addr];
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            regs <= '{default: '0};
        else if (wr_en)
            regs[wb_addr] <= wb_data;
    end

    write_lands: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        (ctl.wb_reg_write && (wb_addr != '0)) |=> regs[$past(wb_addr)] == $past(wb_data))
        else $error("register write did not land");

endmodule

//--- stage_ctrl_if.sv
////////////////////
// stage control interface
// decoded fields out, per-stage control bits back in
////////////////////
`timescale 1ns/1ps

interface stage_ctrl_if import mips_pkg::*; ();

    opcode_e id_opcode;       // from the fetch/decode register
    funct_t  id_funct;

    alu_op_e ex_alu_op;
    logic    ex_alu_src_imm;  // b operand is the immediate
    logic    ex_reg_dst_rd;   // destination is rd, else rt

    logic    mem_read;
    logic    mem_write;

    logic    wb_reg_write;
    logic    wb_mem_to_reg;   // result from memory, else alu

    modport dp
    (
        output id_opcode, id_funct,
        input  ex_alu_op, ex_alu_src_imm, ex_reg_dst_rd,
        input  mem_read, mem_write,
        input  wb_reg_write, wb_mem_to_reg
    );

    modport ctrl
    (
        input  id_opcode, id_funct,
        output ex_alu_op, ex_alu_src_imm, ex_reg_dst_rd,
        output mem_read, mem_write,
        output wb_reg_write, wb_mem_to_reg
    );

endinterface

//--- tb_ref_model.svh
////////////////////
// mips testbench reference model
// in-order program run, lfsr and instruction encoders
////////////////////
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic word_t enc_rtype(input funct_t funct, input reg_addr_t rd,
                                    input reg_addr_t rs, input reg_addr_t rt);
    return {6'h00, rs, rt, rd, 5'd0, funct};
endfunction

function automatic word_t enc_itype(input opcode_e op, input reg_addr_t rt,
                                    input reg_addr_t rs, input imm_t imm);
    return {op, rs, rt, imm};
endfunction

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
        lfsr_state = lfsr_next(lfsr_state);
        bits       = {bits[30:0], lfsr_state[0]};  // one step per bit
    end
    return bits;
endfunction

// runs prog one instruction at a time on exp_regs and ref_mem
function automatic void run_reference(input int len);
    word_t     instr;
    word_t     a;
    word_t     b;
    word_t     imm_ext;
    word_t     addr;
    word_t     result;
    logic      writes;
    reg_addr_t dest;
    int        idx;
    exp_regs = '{default: '0};
    ref_mem  = '{default: '0};
    for (idx = 0; idx < len; idx++)
    begin
        instr   = prog[idx];
        a       = exp_regs[instr[25:21]];
        b       = exp_regs[instr[20:16]];
        imm_ext = {{16{instr[15]}}, instr[15:0]};
        addr    = a + imm_ext;
        dest    = instr[20:16];
        result  = '0;
        writes  = 1'b1;
        case (instr[31:26])
            OP_RTYPE:
            begin
                dest = instr[15:11];
                case (instr[5:0])
                    FUNCT_ADD: result = a + b;
                    FUNCT_SUB: result = a - b;
                    FUNCT_AND: result = a & b;
                    FUNCT_OR:  result = a | b;
                    FUNCT_SLT: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:   writes = 1'b0;  // nop, all-zero word included
                endcase
            end
            OP_ADDI: result = a + imm_ext;
            OP_LW:   result = ref_mem[addr[DMEM_ADDR_W+1:2]];
            OP_SW:
            begin
                ref_mem[addr[DMEM_ADDR_W+1:2]] = b;
                writes = 1'b0;
            end
            default: writes = 1'b0;
        endcase
        if (writes && (dest != 5'd0))
            exp_regs[dest] = result;
    end
endfunction

`endif

//--- tb_mips_pipeline.sv
////////////////////
// mips pipeline testbench
// loads programs, compares all registers with an in-order model
////////////////////
`timescale 1ns/1ps

module tb_mips_pipeline import mips_pkg::*; ();

    localparam int IMEM_ADDR_W = 6;
    localparam int DMEM_ADDR_W = 6;
    localparam int PROG_WORDS  = 2**IMEM_ADDR_W;
    localparam int MAX_PROG    = PROG_WORDS - 8;  // drain ends before the pc wraps

    logic                   SYS_clk;
    logic                   SYS_reset;
    logic                   load_en;
    logic [IMEM_ADDR_W-1:0] load_addr;
    word_t                  load_data;
    reg_addr_t              reg_sel;
    word_t                  reg_value;

    word_t       prog [PROG_WORDS];
    int          prog_len;
    word_t       exp_regs [REG_COUNT];
    word_t       dut_regs [REG_COUNT];
    word_t       ref_mem [2**DMEM_ADDR_W];
    logic [31:0] lfsr_state;
    string       test_name;
    int          test_count;
    int          failed_tests;
    int          error_count;
    logic        compare_done;
    event        regs_captured;

    `include "tb_ref_model.svh"

    mips_pipeline #(.IMEM_ADDR_W(IMEM_ADDR_W), .DMEM_ADDR_W(DMEM_ADDR_W)) mips_pipeline_i
    (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .reg_sel   (reg_sel),
        .reg_value (reg_value)
    );

    always #10 SYS_clk = ~SYS_clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    task automatic wait_falling_edges(input int n);
        int  seen;
        time deadline;
        seen     = 0;
        deadline = $time + (n + 2) * 20;
        while ((seen < n) && ($time <= deadline))
        begin
            @(negedge SYS_clk);
            seen++;
        end
        if (seen < n)
            abort_run("timeout: the clock stopped while waiting for falling edges");
    endtask

    function automatic void clear_program();
        prog     = '{default: '0};
        prog_len = 0;
    endfunction

    function automatic void add_instr(input word_t w);
        prog[prog_len] = w;
        prog_len++;
    endfunction

    // two nops put a consumer three slots behind
    function automatic void add_spaced(input word_t w);
        add_instr(w);
        add_instr('0);
        add_instr('0);
    endfunction

    // even and odd instructions use disjoint register halves
    function automatic word_t random_instr(input logic bank);
        logic [2:0] kind;
        reg_addr_t  rd;
        reg_addr_t  rs;
        reg_addr_t  rt;
        kind = 3'(take_bits(3));
        rd   = reg_addr_t'({take_bits(4), bank});
        rs   = reg_addr_t'({take_bits(4), bank});
        rt   = reg_addr_t'({take_bits(4), bank});
        case (kind)
            3'd0:    return enc_rtype(FUNCT_ADD, rd, rs, rt);
            3'd1:    return enc_rtype(FUNCT_SUB, rd, rs, rt);
            3'd2:    return enc_rtype(FUNCT_AND, rd, rs, rt);
            3'd3:    return enc_rtype(FUNCT_OR, rd, rs, rt);
            3'd4:    return enc_rtype(FUNCT_SLT, rd, rs, rt);
            3'd5:    return enc_itype(OP_ADDI, rd, rs, imm_t'(take_bits(16)));
            3'd6:    return enc_itype(OP_LW, rd, 5'd0, imm_t'(take_bits(5)));  // words 0..7
            default: return enc_itype(OP_SW, rt, 5'd0, imm_t'(take_bits(5)));
        endcase
    endfunction

    task automatic run_test(input string name);
        int a;
        int r;
        int polls;
        if (prog_len > MAX_PROG)
            abort_run("program is too long to finish before the pc wraps");
        test_name = name;
        wait_falling_edges(1);
        SYS_reset = 1'b1;
        wait_falling_edges(8);
        SYS_reset = 1'b0;
        for (a = 0; a < PROG_WORDS; a++)
        begin
            load_en   = 1'b1;
            load_addr = a[IMEM_ADDR_W-1:0];
            load_data = prog[a];  // nops past the program
            wait_falling_edges(1);
        end
        load_en = 1'b0;
        wait_falling_edges(prog_len + 8);
        load_en   = 1'b1;  // pc held while the pipeline drains nops
        load_addr = '1;
        load_data = '0;
        for (r = 0; r < REG_COUNT; r++)
        begin
            reg_sel = r[4:0];
            wait_falling_edges(1);
            dut_regs[r] = reg_value;
        end
        run_reference(prog_len);
        compare_done = 1'b0;
        -> regs_captured;
        polls = 0;
        while (!compare_done && (polls < 4))
        begin
            @(negedge SYS_clk);
            polls++;
        end
        if (!compare_done)
            abort_run("the register compare did not complete");
    endtask

    always @(regs_captured)
    begin
        int r;
        int mismatches;
        mismatches = 0;
        for (r = 0; r < REG_COUNT; r++)
        begin
            if (dut_regs[r] !== exp_regs[r])
            begin
                $display("Error: test %s r%0d expected 0x%08h actual 0x%08h",
                         test_name, r, exp_regs[r], dut_regs[r]);
                mismatches++;
            end
        end
        error_count += mismatches;
        test_count++;
        if (mismatches == 0)
            $display("test %s: ok", test_name);
        else
        begin
            failed_tests++;
            $display("test %s: %0d registers wrong", test_name, mismatches);
        end
        compare_done = 1'b1;
    end

    initial
    begin
        int w;
        int i;
        SYS_clk      = 1'b0;
        SYS_reset    = 1'b1;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        reg_sel      = '0;
        lfsr_state   = 32'h4abbab13;
        test_count   = 0;
        failed_tests = 0;
        error_count  = 0;
        compare_done = 1'b0;

        clear_program();
        run_test("reset_nop");

        clear_program();
        add_spaced(enc_itype(OP_ADDI, 5'd1, 5'd0, 16'd100));
        add_spaced(enc_itype(OP_ADDI, 5'd2, 5'd0, 16'hfff9));  // -7
        add_spaced(enc_itype(OP_ADDI, 5'd3, 5'd0, 16'h7fff));
        add_spaced(enc_itype(OP_ADDI, 5'd4, 5'd0, 16'h8000));  // most negative
        add_spaced(enc_rtype(FUNCT_ADD, 5'd5, 5'd4, 5'd4));    // r4 read as it is written
        add_spaced(enc_rtype(FUNCT_SUB, 5'd6, 5'd2, 5'd1));
        add_spaced(enc_rtype(FUNCT_AND, 5'd7, 5'd1, 5'd2));
        add_spaced(enc_rtype(FUNCT_OR, 5'd8, 5'd3, 5'd4));
        add_spaced(enc_rtype(FUNCT_SLT, 5'd9, 5'd2, 5'd1));    // signed compare true
        add_spaced(enc_rtype(FUNCT_SLT, 5'd10, 5'd1, 5'd2));
        add_spaced(enc_rtype(FUNCT_SLT, 5'd11, 5'd4, 5'd3));
        run_test("alu_ops");

        clear_program();
        add_spaced(enc_itype(OP_ADDI, 5'd1, 5'd0, 16'h0011));
        add_spaced(enc_itype(OP_ADDI, 5'd2, 5'd0, 16'hedcc));
        add_spaced(enc_itype(OP_ADDI, 5'd3, 5'd0, 16'h5a5a));
        add_spaced(enc_itype(OP_ADDI, 5'd5, 5'd0, 16'h0080));  // base register
        add_instr(enc_itype(OP_SW, 5'd1, 5'd0, 16'h0000));
        add_instr(enc_itype(OP_SW, 5'd2, 5'd0, 16'h000c));
        add_instr(enc_itype(OP_SW, 5'd3, 5'd5, 16'h007c));     // last word
        add_instr(enc_itype(OP_SW, 5'd2, 5'd5, 16'hff84));     // negative offset
        add_instr(enc_itype(OP_LW, 5'd10, 5'd0, 16'h0000));
        add_instr(enc_itype(OP_LW, 5'd11, 5'd0, 16'h000c));
        add_instr(enc_itype(OP_LW, 5'd12, 5'd5, 16'h007c));
        add_instr(enc_itype(OP_LW, 5'd13, 5'd0, 16'h0004));
        run_test("store_load");

        clear_program();
        add_spaced(enc_itype(OP_ADDI, 5'd0, 5'd0, 16'd55));
        add_spaced(enc_itype(OP_ADDI, 5'd1, 5'd0, 16'd5));
        add_spaced(enc_itype(OP_ADDI, 5'd2, 5'd0, 16'd9));
        add_spaced(enc_rtype(FUNCT_ADD, 5'd0, 5'd1, 5'd2));
        add_spaced(enc_rtype(FUNCT_ADD, 5'd3, 5'd0, 5'd1));    // sees r0 as zero
        run_test("r0_writes");

        clear_program();
        for (w = 0; w < 8; w++)
            add_instr(enc_itype(OP_SW, 5'd0, 5'd0, imm_t'(w * 4)));  // known loads
        for (i = 0; i < 20; i++)
        begin
            if (i > 0)
                add_instr('0);
            add_instr(random_instr(i[0]));
        end
        run_test("random_program");

        $display("tests run %0d, failed %0d, register mismatches %0d",
                 test_count, failed_tests, error_count);
        if ((failed_tests == 0) && (test_count == 5))
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
mips_pkg.sv
stage_ctrl_if.sv
pipeline_control.sv
fetch_unit.sv
register_file.sv
execute_unit.sv
memory_writeback.sv
mips_pipeline.sv
tb_mips_pipeline.sv
